// ==== sources.f ====
+incdir+tb
verilog/de_cfg_pkg.sv
verilog/de_insn_pkg.sv
verilog/de_hazard_detect.sv
verilog/de_branch_resolve.sv
verilog/de_stage_reg.sv
verilog/decode_execute.sv
tb/tb_decode_execute.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_decode_execute
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sources.f

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/tb_decode_execute_ref.svh ====
// reference model of the decode to execute stage: expected state and decisions

typedef struct packed {
   logic [9:0]  flags;
   opcode_t     opc;
   logic        bubble;
   logic        align;
   logic        valid;
   rf_adr_t     rfd;
   logic [31:0] pc;
   logic [31:0] jal;
   logic [31:0] mtgt;
   logic        pflag;
} exp_state_t;

exp_state_t expd;

function automatic logic interlock_hit();
   return (ctrl_load | ctrl_mfspr) && (rfb_adr == ctrl_rfd);
endfunction

// load or mfspr in execute cannot be bypassed and rfe always stalls
function automatic logic bubble_needed();
   logic late;
   logic hz;
   logic jr;
   late = expd.flags[7] | expd.flags[5];
   hz = late && ((rfa_adr == expd.rfd) || (rfb_adr == expd.rfd));
   jr = dflags[3] && (interlock_hit() || (rfb_adr == expd.rfd));
   return padv && (hz || jr || dflags[0]);
endfunction

function automatic logic [31:0] offset_target();
   return pc_decode + {{4{imm26.offset[25]}}, imm26.offset, 2'b00};
endfunction

function automatic logic imm_branch_taken();
   return dflags[4] && ((opc[2:1] == 2'b00) || (opc[2] == pflag));
endfunction

function automatic logic [31:0] target_pc();
   if (imm_branch_taken())
      return offset_target();
   return (expd.bubble || expd.flags[3]) ? x_rfb : d_rfb;
endfunction

function automatic logic branch_taken();
   return (imm_branch_taken() || (dflags[3] && !interlock_hit())) &&
          !flush && !bubble_needed();
endfunction

function automatic logic [31:0] mispredict_pc();
   return ((op_bf && !pflag) || (op_bnf && pflag)) ? offset_target() : pc_decode + 32'd8;
endfunction

// ==== tb/tb_decode_execute.sv ====
// testbench for the decode to execute stage with a reference model and checker
`timescale 1ns/1ns

module tb_decode_execute;

   import de_cfg_pkg::*;
   import de_insn_pkg::*;

   localparam int reset_cycles = 16;
   localparam int num_random   = 2000;
   localparam int num_directed = 12;
   localparam int timeout_ns   = (reset_cycles + num_random + num_directed) * 20 * 2 +
                                 reset_cycles * 20;

   logic clk = 1'b0;
   logic rst, padv, flush, pflag, ctrl_load, ctrl_mfspr, op_bf, op_bnf, checking;
   logic [31:0] pc_decode, d_rfb, x_rfb;
   logic [9:0] dflags;
   imm26_u imm26;
   opcode_t opc;
   rf_adr_t rfd_adr, rfa_adr, rfb_adr, ctrl_rfd;
   logic [9:0] x_flags;
   logic x_bubble, x_align, x_valid, x_pflag, d_bubble, d_branch;
   rf_adr_t x_rfd;
   opcode_t x_opc;
   logic [31:0] x_pc, x_mtgt, x_jal, d_target;

   `include "tb_decode_execute_ref.svh"

   always #10 clk = ~clk;

   decode_execute i_dut (
      .clk(clk), .rst(rst), .padv_i(padv), .pipeline_flush_i(flush),
      .pc_decode_i(pc_decode), .decode_rfb_i(d_rfb), .execute_rfb_i(x_rfb),
      .predicted_flag_i(pflag), .decode_imm26_i(imm26), .decode_opc_insn_i(opc),
      .decode_rfd_adr_i(rfd_adr), .decode_rfa_adr_i(rfa_adr), .decode_rfb_adr_i(rfb_adr),
      .ctrl_rfd_adr_i(ctrl_rfd), .ctrl_op_lsu_load_i(ctrl_load), .ctrl_op_mfspr_i(ctrl_mfspr),
      .decode_rf_wb_i(dflags[9]), .decode_op_alu_i(dflags[8]),
      .decode_op_lsu_load_i(dflags[7]), .decode_op_lsu_store_i(dflags[6]),
      .decode_op_mfspr_i(dflags[5]), .decode_op_jbr_i(dflags[4]), .decode_op_jr_i(dflags[3]),
      .decode_op_jal_i(dflags[2]), .decode_op_bf_i(op_bf), .decode_op_bnf_i(op_bnf),
      .decode_op_brcond_i(dflags[1]), .decode_op_rfe_i(dflags[0]),
      .execute_rf_wb_o(x_flags[9]), .execute_op_alu_o(x_flags[8]),
      .execute_op_lsu_load_o(x_flags[7]), .execute_op_lsu_store_o(x_flags[6]),
      .execute_op_mfspr_o(x_flags[5]), .execute_op_jbr_o(x_flags[4]),
      .execute_op_jr_o(x_flags[3]), .execute_op_jal_o(x_flags[2]),
      .execute_op_brcond_o(x_flags[1]), .execute_op_rfe_o(x_flags[0]),
      .execute_rfd_adr_o(x_rfd), .execute_opc_insn_o(x_opc), .pc_execute_o(x_pc),
      .execute_except_ibus_align_o(x_align), .execute_predicted_flag_o(x_pflag),
      .execute_mispredict_target_o(x_mtgt), .execute_jal_result_o(x_jal),
      .execute_bubble_o(x_bubble), .decode_valid_o(x_valid), .decode_bubble_o(d_bubble),
      .decode_branch_o(d_branch), .decode_branch_target_o(d_target)
   );

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
      if (got !== want) begin
         $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, want);
         $display("TESTS FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // expected state follows the stage rules with the values before the edge
   always @(posedge clk) begin
      exp_state_t n;
      logic b;
      logic [31:0] tgt;
      n = expd;
      b = bubble_needed();
      tgt = target_pc();
      if (rst || flush) begin
         n.flags = '0;
         n.opc = OPC_NOP;
         n.bubble = 1'b0;
      end else if (padv) begin
         n.flags = b ? {8'b0, dflags[1:0]} : dflags;
         n.opc = b ? OPC_NOP : opc;
         n.bubble = b;
      end
      if (rst)
         n.align = 1'b0;
      else if (padv)
         n.align = branch_taken() && (tgt[1:0] != 2'b00);
      n.valid = !rst && padv;
      if (padv) begin
         n.rfd = rfd_adr;
         n.pc = pc_decode;
         n.jal = pc_decode + 32'd8;
      end
      if (padv && dflags[1]) begin
         n.mtgt = mispredict_pc();
         n.pflag = pflag;
      end
      expd <= n;
   end

   // compare away from the edge where everything is settled
   always @(negedge clk) begin
      if (checking) begin
         check("decode_bubble_o", 32'(d_bubble), 32'(bubble_needed()));
         check("decode_branch_o", 32'(d_branch), 32'(branch_taken()));
         check("decode_branch_target_o", d_target, target_pc());
         check("execute op flags and rf_wb", 32'(x_flags), 32'(expd.flags));
         check("execute_opc_insn_o", 32'(x_opc), 32'(expd.opc));
         check("execute_bubble_o", 32'(x_bubble), 32'(expd.bubble));
         check("execute_except_ibus_align_o", 32'(x_align), 32'(expd.align));
         check("decode_valid_o", 32'(x_valid), 32'(expd.valid));
         check("execute_rfd_adr_o", 32'(x_rfd), 32'(expd.rfd));
         check("pc_execute_o", x_pc, expd.pc);
         check("execute_jal_result_o", x_jal, expd.jal);
         check("execute_mispredict_target_o", x_mtgt, expd.mtgt);
         check("execute_predicted_flag_o", 32'(x_pflag), 32'(expd.pflag));
      end
   end

   // small register range so hazards come often
   task automatic drive_random(input int padv_pct, input int flush_pct);
      logic [9:0] f;
      @(posedge clk);
      f = 10'($urandom) & 10'($urandom);
      f[0] = ($urandom_range(0, 15) == 0);
      opc <= opcode_t'($urandom_range(0, 7));
      op_bf <= f[4] && f[1] && $urandom_range(0, 1) == 1;
      op_bnf <= f[4] && f[1] && $urandom_range(0, 1) == 1;
      dflags <= f;
      padv <= $urandom_range(0, 99) < padv_pct;
      flush <= $urandom_range(0, 99) < flush_pct;
      pflag <= 1'($urandom);
      pc_decode <= {30'($urandom), 2'b00};
      d_rfb <= $urandom;
      x_rfb <= $urandom;
      // the decoder hands the immediate over as upper and low fields
      imm26.fields.upper <= 10'($urandom);
      imm26.fields.low <= 16'($urandom);
      rfd_adr <= rf_adr_t'($urandom_range(0, 3));
      rfa_adr <= rf_adr_t'($urandom_range(0, 3));
      rfb_adr <= rf_adr_t'($urandom_range(0, 3));
      ctrl_rfd <= rf_adr_t'($urandom_range(0, 3));
      ctrl_load <= ($urandom_range(0, 3) == 0);
      ctrl_mfspr <= ($urandom_range(0, 5) == 0);
   endtask

   initial begin
      void'($urandom(32'h9801_b63f));
      checking = 1'b0;
      {padv, flush, pflag, ctrl_load, ctrl_mfspr, op_bf, op_bnf} = '0;
      {pc_decode, d_rfb, x_rfb, imm26, rfd_adr, rfa_adr, rfb_adr, ctrl_rfd} = '0;
      opc = OPC_NOP;
      dflags = 10'b0000000010;
      rst = 1'b1;
      // advance during reset so every data field holds a known value
      padv = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      rst <= 1'b0;
      padv <= 1'b0;
      dflags <= '0;
      checking <= 1'b1;
      for (int i = 0; i < num_random; i++)
         drive_random(85, 4);
      // long hold, then dense advances with frequent flushes
      for (int i = 0; i < num_directed / 2; i++)
         drive_random(0, 0);
      for (int i = 0; i < num_directed / 2; i++)
         drive_random(100, 30);
      @(negedge clk);
      @(negedge clk);
      $display("TESTS PASSED");
      $finish;
   end

   initial begin
      #(timeout_ns);
      $display("TESTS FAILED");
      $fatal(1, "simulation did not finish within the time limit");
   end

endmodule

// ==== verilog/decode_execute.sv ====
// decode to execute stage: hazard bubbles, branch resolution and stage register
`timescale 1ns/1ns

module decode_execute #(
   parameter int operand_width = de_cfg_pkg::OPERAND_WIDTH_DEF,
   parameter bit delay_slot    = 1'b1
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     padv_i,
   input  logic                     pipeline_flush_i,
   input  logic [operand_width-1:0] pc_decode_i,
   input  logic [operand_width-1:0] decode_rfb_i,
   input  logic [operand_width-1:0] execute_rfb_i,
   input  logic                     predicted_flag_i,
   input  de_insn_pkg::imm26_u      decode_imm26_i,
   input  de_insn_pkg::opcode_t     decode_opc_insn_i,
   input  de_cfg_pkg::rf_adr_t      decode_rfd_adr_i,
   input  de_cfg_pkg::rf_adr_t      decode_rfa_adr_i,
   input  de_cfg_pkg::rf_adr_t      decode_rfb_adr_i,
   input  de_cfg_pkg::rf_adr_t      ctrl_rfd_adr_i,
   input  logic                     ctrl_op_lsu_load_i,
   input  logic                     ctrl_op_mfspr_i,
   input  logic                     decode_rf_wb_i,
   input  logic                     decode_op_alu_i,
   input  logic                     decode_op_lsu_load_i,
   input  logic                     decode_op_lsu_store_i,
   input  logic                     decode_op_mfspr_i,
   input  logic                     decode_op_jbr_i,
   input  logic                     decode_op_jr_i,
   input  logic                     decode_op_jal_i,
   input  logic                     decode_op_bf_i,
   input  logic                     decode_op_bnf_i,
   input  logic                     decode_op_brcond_i,
   input  logic                     decode_op_rfe_i,
   output logic                     execute_rf_wb_o,
   output logic                     execute_op_alu_o,
   output logic                     execute_op_lsu_load_o,
   output logic                     execute_op_lsu_store_o,
   output logic                     execute_op_mfspr_o,
   output logic                     execute_op_jbr_o,
   output logic                     execute_op_jr_o,
   output logic                     execute_op_jal_o,
   output logic                     execute_op_brcond_o,
   output logic                     execute_op_rfe_o,
   output de_cfg_pkg::rf_adr_t      execute_rfd_adr_o,
   output de_insn_pkg::opcode_t     execute_opc_insn_o,
   output logic [operand_width-1:0] pc_execute_o,
   output logic                     execute_except_ibus_align_o,
   output logic                     execute_predicted_flag_o,
   output logic [operand_width-1:0] execute_mispredict_target_o,
   output logic [operand_width-1:0] execute_jal_result_o,
   output logic                     execute_bubble_o,
   output logic                     decode_valid_o,
   output logic                     decode_bubble_o,
   output logic                     decode_branch_o,
   output logic [operand_width-1:0] decode_branch_target_o
);

   logic                     ctrl_interlock;
   logic                     misaligned;
   logic [operand_width-1:0] mispredict_target;
   logic [operand_width-1:0] link_pc;

   de_hazard_detect u_hazard (
      .padv_i                (padv_i),
      .decode_op_jr_i        (decode_op_jr_i),
      .decode_op_rfe_i       (decode_op_rfe_i),
      .decode_rfa_adr_i      (decode_rfa_adr_i),
      .decode_rfb_adr_i      (decode_rfb_adr_i),
      .execute_op_lsu_load_i (execute_op_lsu_load_o),
      .execute_op_mfspr_i    (execute_op_mfspr_o),
      .execute_rfd_adr_i     (execute_rfd_adr_o),
      .ctrl_op_lsu_load_i    (ctrl_op_lsu_load_i),
      .ctrl_op_mfspr_i       (ctrl_op_mfspr_i),
      .ctrl_rfd_adr_i        (ctrl_rfd_adr_i),
      .decode_bubble_o       (decode_bubble_o),
      .ctrl_interlock_o      (ctrl_interlock)
   );

   de_branch_resolve #(
      .operand_width (operand_width),
      .delay_slot    (delay_slot)
   ) u_branch (
      .pc_decode_i         (pc_decode_i),
      .decode_imm26_i      (decode_imm26_i),
      .decode_opc_insn_i   (decode_opc_insn_i),
      .predicted_flag_i    (predicted_flag_i),
      .decode_op_jbr_i     (decode_op_jbr_i),
      .decode_op_jr_i      (decode_op_jr_i),
      .decode_op_bf_i      (decode_op_bf_i),
      .decode_op_bnf_i     (decode_op_bnf_i),
      .decode_rfb_i        (decode_rfb_i),
      .execute_rfb_i       (execute_rfb_i),
      .pipeline_flush_i    (pipeline_flush_i),
      .decode_bubble_i     (decode_bubble_o),
      .ctrl_interlock_i    (ctrl_interlock),
      .execute_bubble_i    (execute_bubble_o),
      .execute_op_jr_i     (execute_op_jr_o),
      .decode_branch_o     (decode_branch_o),
      .branch_target_o     (decode_branch_target_o),
      .misaligned_o        (misaligned),
      .mispredict_target_o (mispredict_target),
      .link_pc_o           (link_pc)
   );

   de_stage_reg #(
      .operand_width (operand_width)
   ) u_stage (
      .clk                         (clk),
      .rst                         (rst),
      .padv_i                      (padv_i),
      .pipeline_flush_i            (pipeline_flush_i),
      .decode_bubble_i             (decode_bubble_o),
      .decode_rf_wb_i              (decode_rf_wb_i),
      .decode_op_alu_i             (decode_op_alu_i),
      .decode_op_lsu_load_i        (decode_op_lsu_load_i),
      .decode_op_lsu_store_i       (decode_op_lsu_store_i),
      .decode_op_mfspr_i           (decode_op_mfspr_i),
      .decode_op_jbr_i             (decode_op_jbr_i),
      .decode_op_jr_i              (decode_op_jr_i),
      .decode_op_jal_i             (decode_op_jal_i),
      .decode_op_brcond_i          (decode_op_brcond_i),
      .decode_op_rfe_i             (decode_op_rfe_i),
      .decode_rfd_adr_i            (decode_rfd_adr_i),
      .decode_opc_insn_i           (decode_opc_insn_i),
      .pc_decode_i                 (pc_decode_i),
      .predicted_flag_i            (predicted_flag_i),
      .misaligned_i                (misaligned),
      .mispredict_target_i         (mispredict_target),
      .link_pc_i                   (link_pc),
      .execute_rf_wb_o             (execute_rf_wb_o),
      .execute_op_alu_o            (execute_op_alu_o),
      .execute_op_lsu_load_o       (execute_op_lsu_load_o),
      .execute_op_lsu_store_o      (execute_op_lsu_store_o),
      .execute_op_mfspr_o          (execute_op_mfspr_o),
      .execute_op_jbr_o            (execute_op_jbr_o),
      .execute_op_jr_o             (execute_op_jr_o),
      .execute_op_jal_o            (execute_op_jal_o),
      .execute_op_brcond_o         (execute_op_brcond_o),
      .execute_op_rfe_o            (execute_op_rfe_o),
      .execute_rfd_adr_o           (execute_rfd_adr_o),
      .execute_opc_insn_o          (execute_opc_insn_o),
      .pc_execute_o                (pc_execute_o),
      .execute_except_ibus_align_o (execute_except_ibus_align_o),
      .execute_predicted_flag_o    (execute_predicted_flag_o),
      .execute_mispredict_target_o (execute_mispredict_target_o),
      .execute_jal_result_o        (execute_jal_result_o),
      .execute_bubble_o            (execute_bubble_o),
      .decode_valid_o              (decode_valid_o)
   );

endmodule

// ==== verilog/de_stage_reg.sv ====
// pipeline register from decode into execute with flush and bubble squashing
`timescale 1ns/1ns

module de_stage_reg #(
   parameter int operand_width = 32
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     padv_i,
   input  logic                     pipeline_flush_i,
   input  logic                     decode_bubble_i,
   input  logic                     decode_rf_wb_i,
   input  logic                     decode_op_alu_i,
   input  logic                     decode_op_lsu_load_i,
   input  logic                     decode_op_lsu_store_i,
   input  logic                     decode_op_mfspr_i,
   input  logic                     decode_op_jbr_i,
   input  logic                     decode_op_jr_i,
   input  logic                     decode_op_jal_i,
   input  logic                     decode_op_brcond_i,
   input  logic                     decode_op_rfe_i,
   input  de_cfg_pkg::rf_adr_t      decode_rfd_adr_i,
   input  de_insn_pkg::opcode_t     decode_opc_insn_i,
   input  logic [operand_width-1:0] pc_decode_i,
   input  logic                     predicted_flag_i,
   input  logic                     misaligned_i,
   input  logic [operand_width-1:0] mispredict_target_i,
   input  logic [operand_width-1:0] link_pc_i,
   output logic                     execute_rf_wb_o,
   output logic                     execute_op_alu_o,
   output logic                     execute_op_lsu_load_o,
   output logic                     execute_op_lsu_store_o,
   output logic                     execute_op_mfspr_o,
   output logic                     execute_op_jbr_o,
   output logic                     execute_op_jr_o,
   output logic                     execute_op_jal_o,
   output logic                     execute_op_brcond_o,
   output logic                     execute_op_rfe_o,
   output de_cfg_pkg::rf_adr_t      execute_rfd_adr_o,
   output de_insn_pkg::opcode_t     execute_opc_insn_o,
   output logic [operand_width-1:0] pc_execute_o,
   output logic                     execute_except_ibus_align_o,
   output logic                     execute_predicted_flag_o,
   output logic [operand_width-1:0] execute_mispredict_target_o,
   output logic [operand_width-1:0] execute_jal_result_o,
   output logic                     execute_bubble_o,
   output logic                     decode_valid_o
);

   import de_insn_pkg::*;

   // flags zeroed by a bubble, and the two that ride through it
   logic [7:0] squash_d;
   logic [7:0] squash_q;
   logic [1:0] pass_d;
   logic [1:0] pass_q;

   assign squash_d = {decode_rf_wb_i, decode_op_alu_i, decode_op_lsu_load_i,
                      decode_op_lsu_store_i, decode_op_mfspr_i, decode_op_jbr_i,
                      decode_op_jr_i, decode_op_jal_i};
   assign pass_d   = {decode_op_brcond_i, decode_op_rfe_i};

   assign {execute_rf_wb_o, execute_op_alu_o, execute_op_lsu_load_o,
           execute_op_lsu_store_o, execute_op_mfspr_o, execute_op_jbr_o,
           execute_op_jr_o, execute_op_jal_o} = squash_q;
   assign {execute_op_brcond_o, execute_op_rfe_o} = pass_q;

   always_ff @(posedge clk) begin
      if (rst || pipeline_flush_i) begin
         squash_q           <= '0;
         pass_q             <= '0;
         execute_opc_insn_o <= OPC_NOP;
         execute_bubble_o   <= 1'b0;
      end else if (padv_i) begin
         // rfe keeps going so it reaches ctrl and triggers the return
         squash_q           <= decode_bubble_i ? '0 : squash_d;
         pass_q             <= pass_d;
         execute_opc_insn_o <= decode_bubble_i ? OPC_NOP : decode_opc_insn_i;
         execute_bubble_o   <= decode_bubble_i;
      end
   end

   // alignment exception ignores flush, like the data fields
   always_ff @(posedge clk) begin
      if (rst)
         execute_except_ibus_align_o <= 1'b0;
      else if (padv_i)
         execute_except_ibus_align_o <= misaligned_i;
   end

   always_ff @(posedge clk) begin
      if (rst)
         decode_valid_o <= 1'b0;
      else
         decode_valid_o <= padv_i;
   end

   always_ff @(posedge clk) begin
      if (padv_i) begin
         execute_rfd_adr_o    <= decode_rfd_adr_i;
         pc_execute_o         <= pc_decode_i;
         execute_jal_result_o <= link_pc_i;
      end
   end

   // prediction state only changes for conditional branches
   always_ff @(posedge clk) begin
      if (padv_i && decode_op_brcond_i) begin
         execute_mispredict_target_o <= mispredict_target_i;
         execute_predicted_flag_o    <= predicted_flag_i;
      end
   end

   flush_clears_ops: assert property (
      @(posedge clk) disable iff (rst)
      pipeline_flush_i |=> (squash_q == '0) && (pass_q == '0) && !execute_bubble_o &&
                           (execute_opc_insn_o == OPC_NOP))
      else $error("execute flags survived a pipeline flush");

endmodule

// ==== verilog/de_branch_resolve.sv ====
// branch decision, targets, misprediction target and link result in decode
`timescale 1ns/1ns

module de_branch_resolve #(
   parameter int operand_width = 32,
   parameter bit delay_slot    = 1'b1
) (
   input  logic [operand_width-1:0] pc_decode_i,
   input  de_insn_pkg::imm26_u      decode_imm26_i,
   input  de_insn_pkg::opcode_t     decode_opc_insn_i,
   input  logic                     predicted_flag_i,
   input  logic                     decode_op_jbr_i,
   input  logic                     decode_op_jr_i,
   input  logic                     decode_op_bf_i,
   input  logic                     decode_op_bnf_i,
   input  logic [operand_width-1:0] decode_rfb_i,
   input  logic [operand_width-1:0] execute_rfb_i,
   input  logic                     pipeline_flush_i,
   input  logic                     decode_bubble_i,
   input  logic                     ctrl_interlock_i,
   input  logic                     execute_bubble_i,
   input  logic                     execute_op_jr_i,
   output logic                     decode_branch_o,
   output logic [operand_width-1:0] branch_target_o,
   output logic                     misaligned_o,
   output logic [operand_width-1:0] mispredict_target_o,
   output logic [operand_width-1:0] link_pc_o
);

   // the delay slot instruction is skipped on return
   localparam logic [operand_width-1:0] link_step = delay_slot ? 8 : 4;

   logic                     branch_to_imm;
   logic                     branch_to_reg;
   logic [operand_width-1:0] imm_offset;
   logic [operand_width-1:0] imm_target;
   logic [operand_width-1:0] next_pc;

   // l.j and l.jal always go, bf and bnf only when the flag agrees
   assign branch_to_imm = decode_op_jbr_i &
                          (~|decode_opc_insn_i[2:1] |
                           (decode_opc_insn_i[2] == predicted_flag_i));

   // word offset, sign extended and scaled to bytes
   assign imm_offset = operand_width'($signed(decode_imm26_i.offset)) << 2;
   assign imm_target = pc_decode_i + imm_offset;

   assign branch_to_reg = decode_op_jr_i & ~ctrl_interlock_i;

   assign decode_branch_o = (branch_to_imm | branch_to_reg) &
                            ~pipeline_flush_i & ~decode_bubble_i;

   // after a bubble or back to back jr the register value sits in execute
   always_comb begin
      if (branch_to_imm)
         branch_target_o = imm_target;
      else if (execute_bubble_i | execute_op_jr_i)
         branch_target_o = execute_rfb_i;
      else
         branch_target_o = decode_rfb_i;
   end

   assign misaligned_o = decode_branch_o & (|branch_target_o[1:0]);

   assign next_pc = pc_decode_i + link_step;
   assign link_pc_o = next_pc;

   // where fetch must go if the predicted flag turns out wrong
   assign mispredict_target_o = ((decode_op_bf_i & ~predicted_flag_i) |
                                 (decode_op_bnf_i & predicted_flag_i)) ?
                                imm_target : next_pc;

   always_comb begin
      assert final (!misaligned_o || decode_branch_o)
         else $error("alignment exception without a taken branch");
   end

endmodule

// ==== verilog/de_hazard_detect.sv ====
// operand hazard and jump-register interlock detection for the decode bubble
`timescale 1ns/1ns

module de_hazard_detect (
   input  logic                padv_i,
   input  logic                decode_op_jr_i,
   input  logic                decode_op_rfe_i,
   input  de_cfg_pkg::rf_adr_t decode_rfa_adr_i,
   input  de_cfg_pkg::rf_adr_t decode_rfb_adr_i,
   input  logic                execute_op_lsu_load_i,
   input  logic                execute_op_mfspr_i,
   input  de_cfg_pkg::rf_adr_t execute_rfd_adr_i,
   input  logic                ctrl_op_lsu_load_i,
   input  logic                ctrl_op_mfspr_i,
   input  de_cfg_pkg::rf_adr_t ctrl_rfd_adr_i,
   output logic                decode_bubble_o,
   output logic                ctrl_interlock_o
);

   logic execute_late_result;
   logic operand_hazard;
   logic jr_hazard;

   // ctrl stage result is not ready in time for a jump through rb
   assign ctrl_interlock_o = (ctrl_op_lsu_load_i | ctrl_op_mfspr_i) &
                             (decode_rfb_adr_i == ctrl_rfd_adr_i);

   // load and mfspr produce their result only in ctrl, too late to bypass
   assign execute_late_result = execute_op_lsu_load_i | execute_op_mfspr_i;

   assign operand_hazard = execute_late_result &
                           ((decode_rfa_adr_i == execute_rfd_adr_i) |
                            (decode_rfb_adr_i == execute_rfd_adr_i));

   // the jump target must come from a settled register
   assign jr_hazard = decode_op_jr_i &
                      (ctrl_interlock_o | (decode_rfb_adr_i == execute_rfd_adr_i));

   // rfe always bubbles so fetch stalls while it travels to ctrl
   assign decode_bubble_o = padv_i & (operand_hazard | jr_hazard | decode_op_rfe_i);

   always_comb begin
      assert final (!decode_bubble_o || padv_i)
         else $error("decode bubble raised without pipeline advance");
   end

endmodule

// ==== verilog/de_insn_pkg.sv ====
// instruction encoding: major opcodes and the jump/branch immediate word
package de_insn_pkg;

   localparam int OPCODE_WIDTH = 6;

   typedef logic [OPCODE_WIDTH-1:0] opcode_t;

   // jumps and branches, bit 2 separates bf from bnf
   localparam opcode_t OPC_J   = 6'h00;
   localparam opcode_t OPC_JAL = 6'h01;
   localparam opcode_t OPC_BNF = 6'h03;
   localparam opcode_t OPC_BF  = 6'h04;
   // loaded into execute when nothing valid moves on
   localparam opcode_t OPC_NOP = 6'h05;

   // split of the immediate as the decoder delivers it
   typedef struct packed {
      logic [9:0]  upper;
      logic [15:0] low;
   } imm_fields_t;

   // one 26-bit word, read either as decoder fields or as a word offset
   typedef union packed {
      logic signed [25:0] offset;
      imm_fields_t        fields;
   } imm26_u;

endpackage

// ==== verilog/de_cfg_pkg.sv ====
// decode to execute stage configuration: data, pc and register number widths
package de_cfg_pkg;

   // default data and pc width of the core
   localparam int OPERAND_WIDTH_DEF = 32;

   // gpr number width, 32 registers
   localparam int RF_ADDR_WIDTH = 5;

   typedef logic [RF_ADDR_WIDTH-1:0] rf_adr_t;

endpackage
